// File: all.f
mips_isa_pkg.sv
id_ctrl_pkg.sv
control.sv
operand_fetch.sv
id_issue.sv
decode_stage.sv
decode_stage_props.sv
tb_decode_stage.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f all.f --top-module tb_decode_stage -o sim_tb

run: compile
	./obj_dir/sim_tb | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_decode_stage.sv
`timescale 1ns/1ns

module tb_decode_stage
	import mips_isa_pkg::*;
	import id_ctrl_pkg::*;
();

localparam int N_STROBES   = 240;                       // reads, R, I, flow, special
localparam int STIM_CYCLES = 8 + 33 + 2 * N_STROBES + 8; // each strobe may get one gap

logic        clk;
logic        reset;
logic        in_valid;
logic [31:0] inst;
logic [31:0] pc;
logic        wb_we;
logic [4:0]  wb_addr;
logic [31:0] wb_data;
logic        out_valid;
logic [3:0]  aluop;
logic        alu_trap;
logic [31:0] operand_a;
logic [31:0] operand_b;
logic [31:0] store_data;
logic        mem_we;
logic        mem_rd;
logic [2:0]  res_sel;
logic [4:0]  dest_reg;
logic        dest_we;
logic [4:0]  src_a;
logic [4:0]  src_b;
logic        redirect;
logic [31:0] redirect_target;
logic        cp0_we;
logic [4:0]  cp0_reg;
logic        exc_syscall;
logic        exc_unknown;
logic        eret;

integer       seed;
int           errors;
logic         strobe_last;
logic [31:0]  shadow [32];   // expected register file contents
logic [163:0] exp_q [$];

// expected fields, unpacked from the queue
logic [3:0]  e_aluop;
logic        e_trap;
logic [31:0] e_opa;
logic [31:0] e_opb;
logic [31:0] e_store;
logic        e_mwe;
logic        e_mrd;
logic [2:0]  e_res;
logic [4:0]  e_dst;
logic        e_dwe;
logic [4:0]  e_sa;
logic [4:0]  e_sb;
logic        e_redir;
logic [31:0] e_tgt;
logic        e_c0we;
logic [4:0]  e_c0r;
logic        e_sys;
logic        e_unk;
logic        e_eret;

decode_stage i_dut (.*);

always #5 clk = ~clk;

//////////////////////////////////////////////////////////////////////
// instruction builders
function automatic logic [31:0] r_word(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh, input logic [5:0] fn);
	return {op, rs, rt, rd, sh, fn};
endfunction

function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] j_word(input logic [5:0] op, input logic [25:0] idx);
	return {op, idx};
endfunction

//////////////////////////////////////////////////////////////////////
// reference decode, MIPS encoding rules applied to the shadow registers
function automatic logic [163:0] decode_ref(input logic [31:0] w, input logic [31:0] pc_in);
	logic [5:0]  op;
	logic [5:0]  fn;
	logic [4:0]  rs, rt, rd, sh, dst, sa, sb, c0r;
	logic [3:0]  a_op;
	logic [2:0]  res;
	logic        trap, uimm, sgn, lui, shf, lnk, mwe, mrd, dwe, sys, unk, ert, c0we;
	logic        beq, bne, jmp, jr, redir;
	logic [31:0] rsv, rtv, sext, opa, opb, pc4, tgt;

	op = w[31:26];
	rs = w[25:21];
	rt = w[20:16];
	rd = w[15:11];
	sh = w[10:6];
	fn = w[5:0];
	{dst, sa, sb, c0r} = '0;
	a_op = ALU_AND;
	res = RES_NONE;
	{trap, uimm, sgn, lui, shf, lnk, mwe, mrd, dwe, sys, unk, ert, c0we} = '0;
	{beq, bne, jmp, jr} = '0;

	if (w != 32'd0) begin // all-zero word is a nop
		case (op)
			OP_SPECIAL: begin
				case (fn)
					FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_AND, FN_OR, FN_XOR, FN_NOR: begin
						{res, dst, dwe, sa, sb} = {RES_ALU, rd, 1'b1, rs, rt};
						trap = (fn == FN_ADD) || (fn == FN_SUB); // signed forms trap
						if (fn == FN_ADD || fn == FN_ADDU) a_op = ALU_ADD;
						else if (fn == FN_SUB || fn == FN_SUBU) a_op = ALU_SUB;
						else if (fn == FN_SLT) a_op = ALU_SLT;
						else if (fn == FN_OR) a_op = ALU_OR;
						else if (fn == FN_XOR) a_op = ALU_XOR;
						else if (fn == FN_NOR) a_op = ALU_NOR;
					end
					FN_SLL, FN_SRL: begin
						a_op = (fn == FN_SLL) ? ALU_SLL : ALU_SRL;
						{uimm, shf, res, dst, dwe, sa} = {2'b11, RES_ALU, rd, 1'b1, rt};
					end
					FN_JR: {jr, sa} = {1'b1, rs};
					FN_JALR: begin
						{jr, lnk, a_op, res} = {2'b11, ALU_ADD, RES_ALU};
						{dst, dwe, sa} = {rd, 1'b1, rs};
					end
					FN_SYSCALL: sys = 1'b1;
					FN_MFHI, FN_MFLO: {res, dst, dwe} = {RES_HILO, rd, 1'b1};
					FN_MULT, FN_MULTU: {sa, sb} = {rs, rt};
					FN_MTHI, FN_MTLO: sa = rs;
					default: unk = 1'b1;
				endcase
			end
			OP_LW: {a_op, sgn, uimm, sa, mrd, dst, dwe} = {ALU_ADD, 2'b11, rs, 1'b1, rt, 1'b1};
			OP_SW: {a_op, sgn, uimm, sa, mwe, sb} = {ALU_ADD, 2'b11, rs, 1'b1, rt};
			OP_ADDI: {a_op, sgn, trap, uimm, res, dst, dwe, sa} = {ALU_ADD, 3'b111, RES_ALU, rt, 1'b1, rs};
			OP_ADDIU: {a_op, sgn, uimm, res, dst, dwe, sa} = {ALU_ADD, 2'b11, RES_ALU, rt, 1'b1, rs};
			OP_SLTI: {a_op, sgn, uimm, res, dst, dwe, sa} = {ALU_SLT, 2'b11, RES_ALU, rt, 1'b1, rs};
			OP_ANDI: {a_op, uimm, res, dst, dwe, sa} = {ALU_AND, 1'b1, RES_ALU, rt, 1'b1, rs};
			OP_ORI: {a_op, uimm, res, dst, dwe, sa} = {ALU_OR, 1'b1, RES_ALU, rt, 1'b1, rs};
			OP_XORI: {a_op, uimm, res, dst, dwe, sa} = {ALU_XOR, 1'b1, RES_ALU, rt, 1'b1, rs};
			OP_LUI: {a_op, lui, uimm, res, dst, dwe} = {ALU_OR, 2'b11, RES_ALU, rt, 1'b1};
			OP_BEQ: {beq, sa, sb} = {1'b1, rs, rt};
			OP_BNE: {bne, sa, sb} = {1'b1, rs, rt};
			OP_J: jmp = 1'b1;
			OP_JAL: {jmp, lnk, a_op, res, dst, dwe} = {2'b11, ALU_ADD, RES_ALU, REG_RA, 1'b1};
			OP_COP0: begin
				if (w == INST_ERET) begin
					ert = 1'b1;
				end else if (sh == 5'd0 && fn[5:3] == 3'd0 && rs == 5'd0) begin // mfc0
					{c0r, res, dst, dwe} = {rd, RES_CP0, rt, 1'b1};
				end else if (sh == 5'd0 && fn[5:3] == 3'd0 && rs == 5'd4) begin // mtc0
					{c0r, c0we, sb} = {rd, 1'b1, rt};
				end else begin
					unk = 1'b1;
				end
			end
			OP_SPECIAL2: begin
				if (sh == 5'd0 && fn == FN2_MUL) begin
					{res, dst, dwe, sa, sb} = {RES_HILO, rd, 1'b1, rs, rt};
				end else if (sh == 5'd0 && rd == 5'd0 && (fn == FN2_MADD || fn == FN2_MADDU
						|| fn == FN2_MSUB || fn == FN2_MSUBU)) begin
					{sa, sb} = {rs, rt};
				end else begin
					unk = 1'b1;
				end
			end
			default: unk = 1'b1;
		endcase
	end

	rsv = shadow[rs];
	rtv = shadow[rt];
	sext = {{16{w[15]}}, w[15:0]};
	pc4 = pc_in + 32'd4;
	opa = lnk ? pc_in + 32'd8 : (shf ? rtv : rsv);
	if (lnk) opb = 32'd0;
	else if (!uimm) opb = rtv;
	else if (shf) opb = {27'd0, sh};
	else if (lui) opb = {w[15:0], 16'd0};
	else opb = sgn ? sext : {16'd0, w[15:0]};
	redir = (beq && rsv == rtv) || (bne && rsv != rtv) || jmp || jr;
	if (jr) tgt = rsv;
	else if (jmp) tgt = {pc4[31:28], w[25:0], 2'b00};
	else tgt = pc4 + (sext << 2);
	return {a_op, trap, opa, opb, rtv, mwe, mrd, res, dst, dwe, sa, sb, redir, tgt,
		c0we, c0r, sys, unk, ert};
endfunction

//////////////////////////////////////////////////////////////////////
// checking
task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
	if (act !== exp) begin
		errors++;
		$display("MISMATCH at %0t ns: %s expected %h actual %h", $time, name, exp, act);
		$display("Some tests failed");
		$fatal(1, "stopping at first error");
	end
endtask

always @(posedge clk) strobe_last <= in_valid; // out_valid due one cycle later

always @(negedge clk) begin
	check_value("out_valid", 32'(strobe_last), 32'(out_valid));
	if (out_valid === 1'b1) begin
		{e_aluop, e_trap, e_opa, e_opb, e_store, e_mwe, e_mrd, e_res, e_dst, e_dwe, e_sa, e_sb,
			e_redir, e_tgt, e_c0we, e_c0r, e_sys, e_unk, e_eret} = exp_q.pop_front();
		check_value("aluop", 32'(e_aluop), 32'(aluop));
		check_value("alu_trap", 32'(e_trap), 32'(alu_trap));
		check_value("operand_a", e_opa, operand_a);
		check_value("operand_b", e_opb, operand_b);
		check_value("store_data", e_store, store_data);
		check_value("mem_we", 32'(e_mwe), 32'(mem_we));
		check_value("mem_rd", 32'(e_mrd), 32'(mem_rd));
		check_value("res_sel", 32'(e_res), 32'(res_sel));
		check_value("dest_reg", 32'(e_dst), 32'(dest_reg));
		check_value("dest_we", 32'(e_dwe), 32'(dest_we));
		check_value("src_a", 32'(e_sa), 32'(src_a));
		check_value("src_b", 32'(e_sb), 32'(src_b));
		check_value("redirect", 32'(e_redir), 32'(redirect));
		if (e_redir) check_value("redirect_target", e_tgt, redirect_target);
		check_value("cp0_we", 32'(e_c0we), 32'(cp0_we));
		check_value("cp0_reg", 32'(e_c0r), 32'(cp0_reg));
		check_value("exc_syscall", 32'(e_sys), 32'(exc_syscall));
		check_value("exc_unknown", 32'(e_unk), 32'(exc_unknown));
		check_value("eret", 32'(e_eret), 32'(eret));
	end else begin // idle cycle, every strobe flag low
		check_value("idle flags", 32'd0, 32'({redirect, mem_we, mem_rd, dest_we, cp0_we,
			exc_syscall, exc_unknown, eret}));
	end
end

initial begin
	#((STIM_CYCLES + 100) * 10);
	$display("timeout: the decode stage did not finish within the expected time");
	$display("Some tests failed");
	$fatal(1, "watchdog expired");
end

//////////////////////////////////////////////////////////////////////
// stimulus
task automatic drive_idle();
	@(posedge clk);
	#1;
	in_valid = 1'b0;
	wb_we = 1'b0;
	inst = $random(seed); // garbage must not leak through
endtask

task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
	@(posedge clk);
	#1;
	in_valid = 1'b0;
	wb_we = 1'b1;
	wb_addr = addr;
	wb_data = data;
	if (addr != 5'd0) shadow[addr] = data;
endtask

task automatic send(input logic [31:0] word, input bit gap);
	if (gap && ($random(seed) & 3) == 0) drive_idle();
	@(posedge clk);
	#1;
	wb_we = 1'b0;
	in_valid = 1'b1;
	inst = word;
	pc = $random(seed) & 32'hffff_fffc;
	exp_q.push_back(decode_ref(word, pc));
endtask

initial begin
	logic [5:0] r_fns [$] = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_AND, FN_OR,
		FN_XOR, FN_NOR, FN_SLL, FN_SRL};
	logic [5:0] i_ops [$] = '{OP_LW, OP_SW, OP_ADDI, OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI,
		OP_SLTI, OP_LUI};
	logic [4:0] r, t, d;

	seed = 32'h9d08_da14;
	errors = 0;
	clk = 1'b0;
	reset = 1'b1;
	in_valid = 1'b0;
	inst = 32'd0;
	pc = 32'd0;
	wb_we = 1'b0;
	wb_addr = 5'd0;
	wb_data = 32'd0;
	strobe_last = 1'b0;
	foreach (shadow[k]) shadow[k] = 32'd0;
	repeat (8) @(posedge clk);
	#1 reset = 1'b0;

	for (int k = 1; k < 32; k++) write_reg(5'(k), $random(seed));
	write_reg(5'd0, $random(seed)); // $0 must ignore this
	drive_idle();
	for (int k = 0; k < 32; k++) send(r_word(OP_SPECIAL, 5'(k), 5'(31 - k), 5'd1, 5'd0, FN_OR), 1'b0);

	foreach (r_fns[f]) begin // back to back
		for (int n = 0; n < 4; n++) begin
			r = 5'($random(seed));
			t = 5'($random(seed));
			d = 5'($random(seed));
			send(r_word(OP_SPECIAL, r, t, d, (f > 8) ? 5'($random(seed)) : 5'd0, r_fns[f]), 1'b0);
		end
	end

	foreach (i_ops[o]) begin
		for (int n = 0; n < 4; n++) send(i_word(i_ops[o], 5'($random(seed)), 5'($random(seed)),
			16'($random(seed))), 1'b1);
	end

	for (int n = 0; n < 4; n++) begin // branches and jumps
		r = 5'($random(seed));
		send(i_word(OP_BEQ, r, r, 16'($random(seed))), 1'b1);
		send(i_word(OP_BEQ, r, r ^ 5'd1, 16'($random(seed))), 1'b1);
		send(i_word(OP_BNE, r, r, 16'($random(seed))), 1'b1);
		send(i_word(OP_BNE, r, r ^ 5'd1, 16'($random(seed))), 1'b1);
		send(j_word(OP_J, 26'($random(seed))), 1'b1);
		send(j_word(OP_JAL, 26'($random(seed))), 1'b1);
		send(r_word(OP_SPECIAL, r, 5'd0, 5'd0, 5'd0, FN_JR), 1'b1);
		send(r_word(OP_SPECIAL, r, 5'd0, 5'($random(seed)), 5'd0, FN_JALR), 1'b1);
	end

	for (int n = 0; n < 2; n++) begin // system, cp0 and multiply words
		r = 5'($random(seed));
		t = 5'($random(seed));
		d = 5'($random(seed));
		send(32'd0, 1'b1);
		send(r_word(OP_SPECIAL, 5'd0, 5'd0, 5'd0, 5'd0, FN_SYSCALL), 1'b1);
		send(INST_ERET, 1'b1);
		send(r_word(OP_COP0, 5'd0, t, d, 5'd0, 6'd0), 1'b1);
		send(r_word(OP_COP0, 5'd4, t, d, 5'd0, 6'd0), 1'b1);
		send(r_word(OP_SPECIAL, 5'd0, 5'd0, d, 5'd0, FN_MFHI), 1'b1);
		send(r_word(OP_SPECIAL, 5'd0, 5'd0, d, 5'd0, FN_MFLO), 1'b1);
		send(r_word(OP_SPECIAL, r, t, 5'd0, 5'd0, FN_MULT), 1'b1);
		send(r_word(OP_SPECIAL, r, t, 5'd0, 5'd0, FN_MULTU), 1'b1);
		send(r_word(OP_SPECIAL, r, 5'd0, 5'd0, 5'd0, FN_MTHI), 1'b1);
		send(r_word(OP_SPECIAL, r, 5'd0, 5'd0, 5'd0, FN_MTLO), 1'b1);
		send(r_word(OP_SPECIAL2, r, t, d, 5'd0, FN2_MUL), 1'b1);
		send(r_word(OP_SPECIAL2, r, t, 5'd0, 5'd0, FN2_MADD), 1'b1);
		send(r_word(OP_SPECIAL2, r, t, 5'd0, 5'd0, FN2_MADDU), 1'b1);
		send(r_word(OP_SPECIAL2, r, t, 5'd0, 5'd0, FN2_MSUB), 1'b1);
		send(r_word(OP_SPECIAL2, r, t, 5'd0, 5'd0, FN2_MSUBU), 1'b1);
	end
	for (int n = 0; n < 64; n++) send($random(seed), 1'b1); // mostly unsupported

	repeat (4) drive_idle();
	wait (exp_q.size() == 0);
	repeat (2) @(posedge clk);
	if (errors == 0) begin
		$display("All tests passed");
	end else begin
		$display("Some tests failed");
	end
	$finish;
end

endmodule

// File: decode_stage_props.sv
`timescale 1ns/1ns

module decode_stage_props (
	input logic clk,
	input logic reset,
	input logic out_valid,
	input logic redirect,
	input logic mem_we,
	input logic mem_rd,
	input logic dest_we
);

//////////////////////////////////////////////////////////////////////
// bundle flags seen at the id_issue outputs
valid_after_reset: assert property (@(posedge clk) reset |=> !out_valid)
	else $error("out_valid high during or right after reset");

flags_need_valid: assert property (@(posedge clk) disable iff (reset)
	(redirect || mem_we || dest_we) |-> out_valid)
	else $error("redirect, mem_we or dest_we high without out_valid");

no_load_store: assert property (@(posedge clk) disable iff (reset) !(mem_we && mem_rd))
	else $error("mem_we and mem_rd high together");

endmodule

bind id_issue decode_stage_props i_props (.*);

// File: decode_stage.sv
`timescale 1ns/1ns

module decode_stage
	import mips_isa_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        in_valid,
	input  instr_word_u inst,
	input  logic [31:0] pc,
	input  logic        wb_we,
	input  logic [4:0]  wb_addr,
	input  logic [31:0] wb_data,
	output logic        out_valid,
	output logic [3:0]  aluop,
	output logic        alu_trap,
	output logic [31:0] operand_a,
	output logic [31:0] operand_b,
	output logic [31:0] store_data,
	output logic        mem_we,
	output logic        mem_rd,
	output logic [2:0]  res_sel,
	output logic [4:0]  dest_reg,
	output logic        dest_we,
	output logic [4:0]  src_a,
	output logic [4:0]  src_b,
	output logic        redirect,
	output logic [31:0] redirect_target,
	output logic        cp0_we,
	output logic [4:0]  cp0_reg,
	output logic        exc_syscall,
	output logic        exc_unknown,
	output logic        eret
);

//////////////////////////////////////////////////////////////////////
// decoder to issue
logic       dec_is_beq;
logic       dec_is_bne;
logic       dec_is_j;
logic       dec_is_jr;
logic       dec_is_link;
logic [3:0] dec_aluop;
logic       dec_imm_sign;
logic       dec_use_imm;
logic       dec_is_lui;
logic       dec_is_shift;
logic       dec_alu_trap;
logic       dec_mem_we;
logic       dec_mem_rd;
logic [2:0] dec_res_sel;
logic [4:0] dec_dest_reg;
logic       dec_dest_we;
logic [4:0] dec_src_a;
logic [4:0] dec_src_b;
logic       dec_syscall;
logic       dec_unknown;
logic       dec_eret;
logic       dec_cp0_we;
logic [4:0] dec_cp0_reg;

// operand fetch to issue
logic [31:0] rs_value;
logic [31:0] rt_value;
logic [31:0] imm_sext;
logic [31:0] imm_zext;
logic [31:0] shamt_zext;

control i_control (
	.inst     (inst),
	.is_beq   (dec_is_beq),
	.is_bne   (dec_is_bne),
	.is_j     (dec_is_j),
	.is_jr    (dec_is_jr),
	.is_link  (dec_is_link),
	.aluop    (dec_aluop),
	.imm_sign (dec_imm_sign),
	.use_imm  (dec_use_imm),
	.is_lui   (dec_is_lui),
	.is_shift (dec_is_shift),
	.alu_trap (dec_alu_trap),
	.mem_we   (dec_mem_we),
	.mem_rd   (dec_mem_rd),
	.res_sel  (dec_res_sel),
	.dest_reg (dec_dest_reg),
	.dest_we  (dec_dest_we),
	.src_a    (dec_src_a),
	.src_b    (dec_src_b),
	.syscall  (dec_syscall),
	.unknown  (dec_unknown),
	.eret     (dec_eret),
	.cp0_we   (dec_cp0_we),
	.cp0_reg  (dec_cp0_reg)
);

operand_fetch i_operand_fetch (.*); // runs beside the decoder

id_issue i_id_issue (.*);

endmodule

// File: id_issue.sv
`timescale 1ns/1ns

module id_issue
	import mips_isa_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        in_valid,
	input  instr_word_u inst,
	input  logic [31:0] pc,
	input  logic        dec_is_beq,
	input  logic        dec_is_bne,
	input  logic        dec_is_j,
	input  logic        dec_is_jr,
	input  logic        dec_is_link,
	input  logic [3:0]  dec_aluop,
	input  logic        dec_imm_sign,
	input  logic        dec_use_imm,
	input  logic        dec_is_lui,
	input  logic        dec_is_shift,
	input  logic        dec_alu_trap,
	input  logic        dec_mem_we,
	input  logic        dec_mem_rd,
	input  logic [2:0]  dec_res_sel,
	input  logic [4:0]  dec_dest_reg,
	input  logic        dec_dest_we,
	input  logic [4:0]  dec_src_a,
	input  logic [4:0]  dec_src_b,
	input  logic        dec_syscall,
	input  logic        dec_unknown,
	input  logic        dec_eret,
	input  logic        dec_cp0_we,
	input  logic [4:0]  dec_cp0_reg,
	input  logic [31:0] rs_value,
	input  logic [31:0] rt_value,
	input  logic [31:0] imm_sext,
	input  logic [31:0] imm_zext,
	input  logic [31:0] shamt_zext,
	output logic        out_valid,
	output logic [3:0]  aluop,
	output logic        alu_trap,
	output logic [31:0] operand_a,
	output logic [31:0] operand_b,
	output logic [31:0] store_data,
	output logic        mem_we,
	output logic        mem_rd,
	output logic [2:0]  res_sel,
	output logic [4:0]  dest_reg,
	output logic        dest_we,
	output logic [4:0]  src_a,
	output logic [4:0]  src_b,
	output logic        redirect,
	output logic [31:0] redirect_target,
	output logic        cp0_we,
	output logic [4:0]  cp0_reg,
	output logic        exc_syscall,
	output logic        exc_unknown,
	output logic        eret
);

logic [31:0] pc_plus4;
logic [31:0] op_a_d;
logic [31:0] op_b_d;
logic [31:0] target_d;
logic        take_d;

assign pc_plus4 = pc + 32'd4;

//////////////////////////////////////////////////////////////////////
// operand select
always_comb begin
	if (dec_is_link) begin
		op_a_d = pc + 32'd8; // return address
	end else if (dec_is_shift) begin
		op_a_d = rt_value;
	end else begin
		op_a_d = rs_value;
	end

	if (dec_is_link) begin
		op_b_d = 32'd0;
	end else if (!dec_use_imm) begin
		op_b_d = rt_value;
	end else if (dec_is_shift) begin
		op_b_d = shamt_zext;
	end else if (dec_is_lui) begin
		op_b_d = {imm_zext[15:0], 16'd0};
	end else if (dec_imm_sign) begin
		op_b_d = imm_sext;
	end else begin
		op_b_d = imm_zext;
	end
end

//////////////////////////////////////////////////////////////////////
// branch and jump resolution
assign take_d = (dec_is_beq && rs_value == rt_value) || (dec_is_bne && rs_value != rt_value)
	|| dec_is_j || dec_is_jr;

always_comb begin
	if (dec_is_jr) begin
		target_d = rs_value;
	end else if (dec_is_j) begin
		target_d = {pc_plus4[31:28], inst.j.index, 2'b00}; // region jump
	end else begin
		target_d = pc_plus4 + {imm_sext[29:0], 2'b00};
	end
end

// single-cycle flags, low outside strobe cycles
always_ff @(posedge clk) begin
	if (reset) begin
		out_valid   <= 1'b0;
		redirect    <= 1'b0;
		mem_we      <= 1'b0;
		mem_rd      <= 1'b0;
		dest_we     <= 1'b0;
		cp0_we      <= 1'b0;
		exc_syscall <= 1'b0;
		exc_unknown <= 1'b0;
		eret        <= 1'b0;
	end else begin
		out_valid   <= in_valid;
		redirect    <= in_valid && take_d;
		mem_we      <= in_valid && dec_mem_we;
		mem_rd      <= in_valid && dec_mem_rd;
		dest_we     <= in_valid && dec_dest_we;
		cp0_we      <= in_valid && dec_cp0_we;
		exc_syscall <= in_valid && dec_syscall;
		exc_unknown <= in_valid && dec_unknown;
		eret        <= in_valid && dec_eret;
	end
end

// bundle payload, held between strobes
always_ff @(posedge clk) begin
	if (in_valid) begin
		aluop           <= dec_aluop;
		alu_trap        <= dec_alu_trap;
		operand_a       <= op_a_d;
		operand_b       <= op_b_d;
		store_data      <= rt_value;
		res_sel         <= dec_res_sel;
		dest_reg        <= dec_dest_reg;
		src_a           <= dec_src_a;
		src_b           <= dec_src_b;
		redirect_target <= target_d;
		cp0_reg         <= dec_cp0_reg;
	end
end

endmodule

// File: operand_fetch.sv
`timescale 1ns/1ns

module operand_fetch
	import mips_isa_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  instr_word_u inst,
	input  logic        wb_we,
	input  logic [4:0]  wb_addr,
	input  logic [31:0] wb_data,
	output logic [31:0] rs_value,
	output logic [31:0] rt_value,
	output logic [31:0] imm_sext,
	output logic [31:0] imm_zext,
	output logic [31:0] shamt_zext
);

logic [31:0] regs [32];

//////////////////////////////////////////////////////////////////////
// register file, writes land at the clock edge
always_ff @(posedge clk) begin
	if (reset) begin
		for (int k = 0; k < 32; k++) begin
			regs[k] <= 32'd0;
		end
	end else if (wb_we && wb_addr != 5'd0) begin // $0 stays zero
		regs[wb_addr] <= wb_data;
	end
end

// async reads, old value on same-cycle write
assign rs_value = regs[inst.r.rs];
assign rt_value = regs[inst.r.rt];

//////////////////////////////////////////////////////////////////////
// immediate forms
assign imm_sext   = {{16{inst.i.imm[15]}}, inst.i.imm};
assign imm_zext   = {16'd0, inst.i.imm};
assign shamt_zext = {27'd0, inst.r.shamt};

endmodule

// File: control.sv
`timescale 1ns/1ns

module control
	import mips_isa_pkg::*;
	import id_ctrl_pkg::*;
(
	input  instr_word_u inst,
	output logic        is_beq,
	output logic        is_bne,
	output logic        is_j,
	output logic        is_jr,
	output logic        is_link,
	output logic [3:0]  aluop,
	output logic        imm_sign,
	output logic        use_imm,
	output logic        is_lui,
	output logic        is_shift,
	output logic        alu_trap,
	output logic        mem_we,
	output logic        mem_rd,
	output logic [2:0]  res_sel,
	output logic [4:0]  dest_reg,
	output logic        dest_we,
	output logic [4:0]  src_a,
	output logic [4:0]  src_b,
	output logic        syscall,
	output logic        unknown,
	output logic        eret,
	output logic        cp0_we,
	output logic [4:0]  cp0_reg
);

always_comb begin
	is_beq   = 1'b0;
	is_bne   = 1'b0;
	is_j     = 1'b0;
	is_jr    = 1'b0;
	is_link  = 1'b0;
	aluop    = ALU_AND;
	imm_sign = 1'b0;
	use_imm  = 1'b0;
	is_lui   = 1'b0;
	is_shift = 1'b0;
	alu_trap = 1'b0;
	mem_we   = 1'b0;
	mem_rd   = 1'b0;
	res_sel  = RES_NONE;
	dest_reg = 5'd0;
	dest_we  = 1'b0;
	src_a    = 5'd0; // unused sources stay 0, never a hazard
	src_b    = 5'd0;
	syscall  = 1'b0;
	unknown  = 1'b0;
	eret     = 1'b0;
	cp0_we   = 1'b0;
	cp0_reg  = 5'd0;

	if (inst == 32'd0) begin
		// nop raises nothing
	end else begin
		case (inst.r.op)
			////////////////////////////////////////////////////////////////
			// R-type
			OP_SPECIAL: begin
				case (inst.r.funct)
					FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT,
					FN_AND, FN_OR, FN_XOR, FN_NOR: begin
						dest_reg = inst.r.rd;
						dest_we  = 1'b1;
						src_a    = inst.r.rs;
						src_b    = inst.r.rt;
						res_sel  = RES_ALU;
						alu_trap = (inst.r.funct == FN_ADD) || (inst.r.funct == FN_SUB);
						case (inst.r.funct)
							FN_ADD, FN_ADDU: aluop = ALU_ADD;
							FN_SUB, FN_SUBU: aluop = ALU_SUB;
							FN_SLT:          aluop = ALU_SLT;
							FN_AND:          aluop = ALU_AND;
							FN_OR:           aluop = ALU_OR;
							FN_XOR:          aluop = ALU_XOR;
							default:         aluop = ALU_NOR;
						endcase
					end
					FN_SRL, FN_SLL: begin
						aluop    = (inst.r.funct == FN_SRL) ? ALU_SRL : ALU_SLL;
						use_imm  = 1'b1; // shamt as B
						is_shift = 1'b1;
						dest_reg = inst.r.rd;
						dest_we  = 1'b1;
						src_a    = inst.r.rt; // shifted value comes from rt
						res_sel  = RES_ALU;
					end
					FN_JR: begin
						is_jr = 1'b1;
						src_a = inst.r.rs;
					end
					FN_JALR: begin
						is_jr    = 1'b1;
						is_link  = 1'b1;
						aluop    = ALU_ADD; // pc+8 plus zero
						dest_reg = inst.r.rd;
						dest_we  = 1'b1;
						src_a    = inst.r.rs;
						res_sel  = RES_ALU;
					end
					FN_SYSCALL: syscall = 1'b1;
					FN_MFHI, FN_MFLO: begin
						res_sel  = RES_HILO;
						dest_reg = inst.r.rd;
						dest_we  = 1'b1;
					end
					FN_MULT, FN_MULTU: begin
						src_a = inst.r.rs;
						src_b = inst.r.rt;
					end
					FN_MTHI, FN_MTLO: src_a = inst.r.rs;
					default: unknown = 1'b1;
				endcase
			end
			OP_LW, OP_SW: begin
				aluop    = ALU_ADD; // base + offset
				imm_sign = 1'b1;
				use_imm  = 1'b1;
				src_a    = inst.i.rs;
				if (inst.i.op == OP_LW) begin
					mem_rd   = 1'b1;
					dest_reg = inst.i.rt;
					dest_we  = 1'b1;
				end else begin
					mem_we = 1'b1;
					src_b  = inst.i.rt; // store data
				end
			end
			////////////////////////////////////////////////////////////////
			// I-type ALU
			OP_ADDI, OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_LUI: begin
				use_imm  = 1'b1;
				res_sel  = RES_ALU;
				dest_reg = inst.i.rt;
				dest_we  = 1'b1;
				src_a    = inst.i.rs;
				case (inst.i.op)
					OP_ADDI: begin
						aluop    = ALU_ADD;
						imm_sign = 1'b1;
						alu_trap = 1'b1;
					end
					OP_ADDIU: begin
						aluop    = ALU_ADD;
						imm_sign = 1'b1;
					end
					OP_ANDI: aluop = ALU_AND;
					OP_ORI:  aluop = ALU_OR;
					OP_XORI: aluop = ALU_XOR;
					OP_SLTI: begin
						aluop    = ALU_SLT;
						imm_sign = 1'b1;
					end
					default: begin // lui
						aluop  = ALU_OR;
						is_lui = 1'b1;
						src_a  = 5'd0;
					end
				endcase
			end
			OP_BEQ, OP_BNE: begin
				is_beq = (inst.i.op == OP_BEQ);
				is_bne = (inst.i.op == OP_BNE);
				src_a  = inst.i.rs;
				src_b  = inst.i.rt;
			end
			OP_J: is_j = 1'b1;
			OP_JAL: begin
				is_j     = 1'b1;
				is_link  = 1'b1;
				aluop    = ALU_ADD;
				res_sel  = RES_ALU;
				dest_reg = REG_RA;
				dest_we  = 1'b1;
			end
			////////////////////////////////////////////////////////////////
			// coprocessor 0 and SPECIAL2
			OP_COP0: begin
				if (inst == INST_ERET) begin
					eret = 1'b1;
				end else if (inst.r.shamt == 5'd0 && inst.r.funct[5:3] == 3'd0
						&& (inst.r.rs == 5'd0 || inst.r.rs == 5'd4)) begin
					cp0_reg = inst.r.rd;
					if (inst.r.rs == 5'd0) begin // mfc0
						res_sel  = RES_CP0;
						dest_reg = inst.r.rt;
						dest_we  = 1'b1;
					end else begin // mtc0, value rides on store_data
						cp0_we = 1'b1;
						src_b  = inst.r.rt;
					end
				end else begin
					unknown = 1'b1;
				end
			end
			OP_SPECIAL2: begin
				if (inst.r.shamt == 5'd0 && inst.r.funct == FN2_MUL) begin
					res_sel  = RES_HILO;
					dest_reg = inst.r.rd;
					dest_we  = 1'b1;
					src_a    = inst.r.rs;
					src_b    = inst.r.rt;
				end else if (inst.r.shamt == 5'd0 && inst.r.rd == 5'd0
						&& (inst.r.funct == FN2_MADD || inst.r.funct == FN2_MADDU
						|| inst.r.funct == FN2_MSUB || inst.r.funct == FN2_MSUBU)) begin
					src_a = inst.r.rs; // accumulate into hi/lo
					src_b = inst.r.rt;
				end else begin
					unknown = 1'b1;
				end
			end
			default: unknown = 1'b1;
		endcase
	end
end

endmodule

// File: id_ctrl_pkg.sv
package id_ctrl_pkg;

	//////////////////////////////////////////////////////////////////////
	// ALU operation codes
	localparam logic [3:0] ALU_AND = 4'b0000;
	localparam logic [3:0] ALU_OR  = 4'b0001;
	localparam logic [3:0] ALU_ADD = 4'b0010;
	localparam logic [3:0] ALU_XOR = 4'b0011;
	localparam logic [3:0] ALU_NOR = 4'b0100;
	localparam logic [3:0] ALU_SRL = 4'b0101;
	localparam logic [3:0] ALU_SUB = 4'b0110;
	localparam logic [3:0] ALU_SLT = 4'b0111; // signed compare
	localparam logic [3:0] ALU_SLL = 4'b1000;

	//////////////////////////////////////////////////////////////////////
	// writeback result source, load data goes by mem_rd instead
	localparam logic [2:0] RES_NONE = 3'b000;
	localparam logic [2:0] RES_ALU  = 3'b001;
	localparam logic [2:0] RES_CP0  = 3'b010;
	localparam logic [2:0] RES_HILO = 3'b011;

endpackage

// File: mips_isa_pkg.sv
package mips_isa_pkg;

	//////////////////////////////////////////////////////////////////////
	// primary opcodes
	localparam logic [5:0] OP_SPECIAL  = 6'h00;
	localparam logic [5:0] OP_J        = 6'h02;
	localparam logic [5:0] OP_JAL      = 6'h03;
	localparam logic [5:0] OP_BEQ      = 6'h04;
	localparam logic [5:0] OP_BNE      = 6'h05;
	localparam logic [5:0] OP_ADDI     = 6'h08;
	localparam logic [5:0] OP_ADDIU    = 6'h09;
	localparam logic [5:0] OP_SLTI     = 6'h0a;
	localparam logic [5:0] OP_ANDI     = 6'h0c;
	localparam logic [5:0] OP_ORI      = 6'h0d;
	localparam logic [5:0] OP_XORI     = 6'h0e;
	localparam logic [5:0] OP_LUI      = 6'h0f;
	localparam logic [5:0] OP_COP0     = 6'h10;
	localparam logic [5:0] OP_SPECIAL2 = 6'h1c;
	localparam logic [5:0] OP_LW       = 6'h23;
	localparam logic [5:0] OP_SW       = 6'h2b;

	//////////////////////////////////////////////////////////////////////
	// function codes, SPECIAL then SPECIAL2
	localparam logic [5:0] FN_SLL     = 6'h00;
	localparam logic [5:0] FN_SRL     = 6'h02;
	localparam logic [5:0] FN_JR      = 6'h08;
	localparam logic [5:0] FN_JALR    = 6'h09;
	localparam logic [5:0] FN_SYSCALL = 6'h0c;
	localparam logic [5:0] FN_MFHI    = 6'h10;
	localparam logic [5:0] FN_MTHI    = 6'h11;
	localparam logic [5:0] FN_MFLO    = 6'h12;
	localparam logic [5:0] FN_MTLO    = 6'h13;
	localparam logic [5:0] FN_MULT    = 6'h18;
	localparam logic [5:0] FN_MULTU   = 6'h19;
	localparam logic [5:0] FN_ADD     = 6'h20;
	localparam logic [5:0] FN_ADDU    = 6'h21;
	localparam logic [5:0] FN_SUB     = 6'h22;
	localparam logic [5:0] FN_SUBU    = 6'h23;
	localparam logic [5:0] FN_AND     = 6'h24;
	localparam logic [5:0] FN_OR      = 6'h25;
	localparam logic [5:0] FN_XOR     = 6'h26;
	localparam logic [5:0] FN_NOR     = 6'h27;
	localparam logic [5:0] FN_SLT     = 6'h2a;
	localparam logic [5:0] FN2_MADD   = 6'h00;
	localparam logic [5:0] FN2_MADDU  = 6'h01;
	localparam logic [5:0] FN2_MUL    = 6'h02;
	localparam logic [5:0] FN2_MSUB   = 6'h04;
	localparam logic [5:0] FN2_MSUBU  = 6'h05;

	localparam logic [31:0] INST_ERET = 32'h4200_0018; // cop0 co=1, funct 0x18
	localparam logic [4:0]  REG_RA    = 5'd31;         // jal link register

	// one instruction word, three field layouts
	typedef union packed {
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0]  op;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm;
		} i;
		struct packed {
			logic [5:0]  op;
			logic [25:0] index;
		} j;
	} instr_word_u;

endpackage
